/* rtl/ncpu_bus_pkg.sv */
// Payload structs for the channels between fetch stages and to memory.
// every channel pairs one of these with its own valid/ready
`default_nettype none

package ncpu_bus_pkg;

   // fetch command, ifu to mmu
   typedef struct packed {
      // virtual fetch address
      logic [ncpu_cfg_pkg::ncpu_aw-1:0] addr;
   } fetch_cmd_t;

   // fetch response, mmu to ifu and ifu to the outside
   typedef struct packed {
      logic [ncpu_cfg_pkg::ncpu_iw-1:0] insn;
      // virtual address the word was fetched from
      logic [ncpu_cfg_pkg::ncpu_aw-1:0] id;
   } fetch_rsp_t;

   // cache command, mmu to icache
   typedef struct packed {
      // translated address used for index and tag
      logic [ncpu_cfg_pkg::ncpu_aw-1:0] paddr;
      // virtual address, carried through untouched
      logic [ncpu_cfg_pkg::ncpu_aw-1:0] id;
   } icache_cmd_t;

   // cache response, icache to mmu
   typedef struct packed {
      logic [ncpu_cfg_pkg::ncpu_iw-1:0] insn;
      logic [ncpu_cfg_pkg::ncpu_aw-1:0] id;
   } icache_rsp_t;

   // tlb entry write, from outside into the mmu
   typedef struct packed {
      // entry to overwrite
      logic [1:0] idx;
      // virtual page number
      logic [ncpu_cfg_pkg::ncpu_aw-ncpu_cfg_pkg::ncpu_page_bits-1:0] vpn;
      // physical page number
      logic [ncpu_cfg_pkg::ncpu_aw-ncpu_cfg_pkg::ncpu_page_bits-1:0] ppn;
      // entry enable, 0 retires the entry
      logic valid;
   } tlb_wr_t;

   // memory read request from the cache refill
   typedef struct packed {
      // byte address of the word, low two bits zero
      logic [ncpu_cfg_pkg::ncpu_aw-1:0] addr;
   } mem_req_t;

endpackage

`default_nettype wire

/* rtl/ncpu_cfg_pkg.sv */
// CPU configuration shared by every fetch-path block.
// widths, reset vector and the two views of an instruction word
`default_nettype none

package ncpu_cfg_pkg;

   // address and instruction widths
   localparam int unsigned ncpu_aw = 32;
   localparam int unsigned ncpu_iw = 32;

   // first fetch address out of reset
   localparam logic [ncpu_aw-1:0] ncpu_erst_vector = 32'h0000_0100;

   // page offset width, the rest of the address is the page number
   localparam int unsigned ncpu_page_bits = 12;

   // opcode of the unconditional jump
   localparam logic [5:0] opc_jmp = 6'h01;

   // one instruction word, decoded two ways
   typedef union packed {
      // generic register/immediate form
      struct packed {
         logic [5:0]  opc;
         logic [4:0]  rd;
         logic [4:0]  rs;
         logic [15:0] imm;
      } gen;
      // jump form, offs counts words and is signed
      struct packed {
         logic [5:0]  opc;
         logic [25:0] offs;
      } jmp;
   } ncpu_insn_u;

endpackage

`default_nettype wire

/* rtl/ncpu_fetch_top.sv */
// Fetch front end. chains ifu -> immu -> icache and exposes the
// tlb write port, the instruction output and the memory port.
`timescale 1ns/100ps
`default_nettype none

module ncpu_fetch_top #(
   parameter int unsigned tlb_entries  = 4,
   parameter int unsigned icache_lines = 16
) (
   input  wire                             clk,
   input  wire                             rst_n,
   input  wire                             tlb_we,
   input  wire ncpu_bus_pkg::tlb_wr_t      tlb_wr,
   output logic                            insn_valid,
   output ncpu_bus_pkg::fetch_rsp_t        insn,
   input  wire                             insn_ready,
   output logic                            mem_req_valid,
   output ncpu_bus_pkg::mem_req_t          mem_req,
   input  wire                             mem_req_ready,
   input  wire                             mem_rsp_valid,
   input  wire [ncpu_cfg_pkg::ncpu_iw-1:0] mem_rsp_data
);

   // ifu <-> immu
   logic                        fetch_cmd_valid;
   logic                        fetch_cmd_ready;
   ncpu_bus_pkg::fetch_cmd_t    fetch_cmd;
   logic                        fetch_rsp_valid;
   logic                        fetch_rsp_ready;
   ncpu_bus_pkg::fetch_rsp_t    fetch_rsp;

   // immu <-> icache
   logic                        icache_cmd_valid;
   logic                        icache_cmd_ready;
   ncpu_bus_pkg::icache_cmd_t   icache_cmd;
   logic                        icache_rsp_valid;
   logic                        icache_rsp_ready;
   ncpu_bus_pkg::icache_rsp_t   icache_rsp;

   ncpu_ifu u_ifu (
      .clk             (clk),
      .rst_n           (rst_n),
      .fetch_cmd_valid (fetch_cmd_valid),
      .fetch_cmd       (fetch_cmd),
      .fetch_cmd_ready (fetch_cmd_ready),
      .fetch_rsp_valid (fetch_rsp_valid),
      .fetch_rsp       (fetch_rsp),
      .fetch_rsp_ready (fetch_rsp_ready),
      .insn_valid      (insn_valid),
      .insn            (insn),
      .insn_ready      (insn_ready)
   );

   ncpu_i_mmu #(
      .tlb_entries (tlb_entries)
   ) u_i_mmu (
      .clk              (clk),
      .rst_n            (rst_n),
      .fetch_cmd_valid  (fetch_cmd_valid),
      .fetch_cmd        (fetch_cmd),
      .fetch_cmd_ready  (fetch_cmd_ready),
      .fetch_rsp_valid  (fetch_rsp_valid),
      .fetch_rsp        (fetch_rsp),
      .fetch_rsp_ready  (fetch_rsp_ready),
      .tlb_we           (tlb_we),
      .tlb_wr           (tlb_wr),
      .icache_cmd_valid (icache_cmd_valid),
      .icache_cmd       (icache_cmd),
      .icache_cmd_ready (icache_cmd_ready),
      .icache_rsp_valid (icache_rsp_valid),
      .icache_rsp       (icache_rsp),
      .icache_rsp_ready (icache_rsp_ready)
   );

   ncpu_icache #(
      .icache_lines (icache_lines)
   ) u_icache (
      .clk              (clk),
      .rst_n            (rst_n),
      .icache_cmd_valid (icache_cmd_valid),
      .icache_cmd       (icache_cmd),
      .icache_cmd_ready (icache_cmd_ready),
      .icache_rsp_valid (icache_rsp_valid),
      .icache_rsp       (icache_rsp),
      .icache_rsp_ready (icache_rsp_ready),
      .mem_req_valid    (mem_req_valid),
      .mem_req          (mem_req),
      .mem_req_ready    (mem_req_ready),
      .mem_rsp_valid    (mem_rsp_valid),
      .mem_rsp_data     (mem_rsp_data)
   );

endmodule

`default_nettype wire

/* rtl/ncpu_i_mmu.sv */
// Instruction MMU. accepts one fetch, translates it through a small
// software-loaded TLB and forwards it to the instruction cache.
`timescale 1ns/100ps
`default_nettype none

module ncpu_i_mmu #(
   parameter int unsigned tlb_entries = 4
) (
   input  wire                            clk,
   input  wire                            rst_n,
   input  wire                            fetch_cmd_valid,
   input  wire ncpu_bus_pkg::fetch_cmd_t  fetch_cmd,
   output logic                           fetch_cmd_ready,
   output logic                           fetch_rsp_valid,
   output ncpu_bus_pkg::fetch_rsp_t       fetch_rsp,
   input  wire                            fetch_rsp_ready,
   input  wire                            tlb_we,
   input  wire ncpu_bus_pkg::tlb_wr_t     tlb_wr,
   output logic                           icache_cmd_valid,
   output ncpu_bus_pkg::icache_cmd_t      icache_cmd,
   input  wire                            icache_cmd_ready,
   input  wire                            icache_rsp_valid,
   input  wire ncpu_bus_pkg::icache_rsp_t icache_rsp,
   output logic                           icache_rsp_ready
);

   localparam int unsigned aw    = ncpu_cfg_pkg::ncpu_aw;
   localparam int unsigned pgb   = ncpu_cfg_pkg::ncpu_page_bits;
   localparam int unsigned vpn_w = aw - pgb;

   // mmu fsm
   localparam logic ms_idle      = 1'b0;
   localparam logic ms_translate = 1'b1;

   logic                   status_q;
   // cache command not yet taken
   logic                   cmd_pend_q;
   logic [aw-1:0]          id_q;
   logic [aw-1:0]          paddr_q;
   logic [aw-1:0]          paddr_nxt;

   // fully associative tlb
   logic [tlb_entries-1:0] tlb_v_q;
   logic [vpn_w-1:0]       tlb_vpn_q [tlb_entries];
   logic [vpn_w-1:0]       tlb_ppn_q [tlb_entries];
   logic                   tlb_hit;
   logic [vpn_w-1:0]       hit_ppn;

   logic                   hds_cmd;
   logic                   hds_icache_cmd;
   logic                   hds_rsp;

   assign hds_cmd        = fetch_cmd_valid & fetch_cmd_ready;
   assign hds_icache_cmd = icache_cmd_valid & icache_cmd_ready;
   assign hds_rsp        = fetch_rsp_valid & fetch_rsp_ready;

   // only take a command when idle
   assign fetch_cmd_ready = (status_q == ms_idle);

   assign icache_cmd_valid = cmd_pend_q;
   assign icache_cmd       = '{paddr: paddr_q, id: id_q};

   // response passes straight through to the ifu
   assign fetch_rsp_valid  = icache_rsp_valid & (status_q == ms_translate);
   assign fetch_rsp        = '{insn: icache_rsp.insn, id: icache_rsp.id};
   assign icache_rsp_ready = fetch_rsp_ready;

   // page match on the incoming virtual address
   always_comb begin
      tlb_hit = 1'b0;
      hit_ppn = '0;
      for (int i = 0; i < tlb_entries; i++) begin
         if (tlb_v_q[i] && (tlb_vpn_q[i] == fetch_cmd.addr[aw-1:pgb])) begin
            tlb_hit = 1'b1;
            hit_ppn = tlb_ppn_q[i];
         end
      end
   end

   // a miss just passes the address through
   assign paddr_nxt = tlb_hit ? {hit_ppn, fetch_cmd.addr[pgb-1:0]} : fetch_cmd.addr;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         status_q   <= ms_idle;
         cmd_pend_q <= 1'b0;
      end else begin
         if (hds_cmd) begin
            status_q <= ms_translate;
         end else if (hds_rsp) begin
            status_q <= ms_idle;
         end
         // cache command shows up the cycle after acceptance
         if (hds_cmd) begin
            cmd_pend_q <= 1'b1;
         end else if (hds_icache_cmd) begin
            cmd_pend_q <= 1'b0;
         end
      end
   end

   // translated address and id, captured at acceptance
   always_ff @(posedge clk) begin
      if (hds_cmd) begin
         paddr_q <= paddr_nxt;
         id_q    <= fetch_cmd.addr;
      end
   end

   // tlb valid bits
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         tlb_v_q <= '0;
      end else if (tlb_we) begin
         tlb_v_q[tlb_wr.idx] <= tlb_wr.valid;
      end
   end

   // tlb page numbers
   always_ff @(posedge clk) begin
      if (tlb_we) begin
         tlb_vpn_q[tlb_wr.idx] <= tlb_wr.vpn;
         tlb_ppn_q[tlb_wr.idx] <= tlb_wr.ppn;
      end
   end

endmodule

`default_nettype wire

/* rtl/ncpu_icache.sv */
// Direct-mapped instruction cache, one word per line.
// a miss refills the line from the memory port, then responds
`timescale 1ns/100ps
`default_nettype none

module ncpu_icache #(
   parameter int unsigned icache_lines = 16
) (
   input  wire                            clk,
   input  wire                            rst_n,
   input  wire                            icache_cmd_valid,
   input  wire ncpu_bus_pkg::icache_cmd_t icache_cmd,
   output logic                           icache_cmd_ready,
   output logic                           icache_rsp_valid,
   output ncpu_bus_pkg::icache_rsp_t      icache_rsp,
   input  wire                            icache_rsp_ready,
   output logic                           mem_req_valid,
   output ncpu_bus_pkg::mem_req_t         mem_req,
   input  wire                            mem_req_ready,
   input  wire                            mem_rsp_valid,
   input  wire [ncpu_cfg_pkg::ncpu_iw-1:0] mem_rsp_data
);

   localparam int unsigned aw    = ncpu_cfg_pkg::ncpu_aw;
   localparam int unsigned iw    = ncpu_cfg_pkg::ncpu_iw;
   localparam int unsigned idx_w = $clog2(icache_lines);
   // above the index and the byte offset
   localparam int unsigned tag_w = aw - idx_w - 2;

   typedef enum logic [2:0] {
      cs_idle,
      cs_lookup,
      cs_refill_req,
      cs_refill_wait,
      cs_respond
   } cache_state_e;

   cache_state_e               state_q;
   cache_state_e               state_nxt;
   ncpu_bus_pkg::icache_cmd_t  cmd_q;
   logic [iw-1:0]              rsp_data_q;

   // line storage
   logic [icache_lines-1:0]    line_v_q;
   logic [tag_w-1:0]           tag_arr [icache_lines];
   logic [iw-1:0]              data_arr [icache_lines];

   logic [idx_w-1:0]           idx;
   logic [tag_w-1:0]           tag;
   logic                       hit;
   logic                       hds_cmd;
   logic                       refill_done;

   assign hds_cmd = icache_cmd_valid & icache_cmd_ready;

   // word address split
   assign idx = cmd_q.paddr[idx_w+1:2];
   assign tag = cmd_q.paddr[aw-1:idx_w+2];
   assign hit = line_v_q[idx] & (tag_arr[idx] == tag);

   assign refill_done = (state_q == cs_refill_wait) & mem_rsp_valid;

   assign icache_cmd_ready = (state_q == cs_idle);

   // hit answers straight from the array in the lookup cycle
   assign icache_rsp_valid = ((state_q == cs_lookup) & hit) | (state_q == cs_respond);
   assign icache_rsp.insn  = (state_q == cs_lookup) ? data_arr[idx] : rsp_data_q;
   assign icache_rsp.id    = cmd_q.id;

   // refill reads the whole word
   assign mem_req_valid = (state_q == cs_refill_req);
   assign mem_req       = '{addr: {cmd_q.paddr[aw-1:2], 2'b00}};

   always_comb begin
      state_nxt = state_q;
      case (state_q)
         cs_idle: begin
            if (hds_cmd) begin
               state_nxt = cs_lookup;
            end
         end
         cs_lookup: begin
            if (hit && icache_rsp_ready) begin
               state_nxt = cs_idle;
            end else if (hit) begin
               // stalled hit, park in respond
               state_nxt = cs_respond;
            end else begin
               state_nxt = cs_refill_req;
            end
         end
         cs_refill_req: begin
            if (mem_req_ready) begin
               state_nxt = cs_refill_wait;
            end
         end
         cs_refill_wait: begin
            if (mem_rsp_valid) begin
               state_nxt = cs_respond;
            end
         end
         cs_respond: begin
            if (icache_rsp_ready) begin
               state_nxt = cs_idle;
            end
         end
         default: begin
            state_nxt = cs_idle;
         end
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state_q <= cs_idle;
      end else begin
         state_q <= state_nxt;
      end
   end

   // line valid bits, all empty out of reset
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         line_v_q <= '0;
      end else if (refill_done) begin
         line_v_q[idx] <= 1'b1;
      end
   end

   // command, response word and line fill
   always_ff @(posedge clk) begin
      if (hds_cmd) begin
         cmd_q <= icache_cmd;
      end
      // lookup copy keeps a stalled hit stable in respond
      if (state_q == cs_lookup) begin
         rsp_data_q <= data_arr[idx];
      end else if (refill_done) begin
         rsp_data_q <= mem_rsp_data;
      end
      if (refill_done) begin
         tag_arr[idx]  <= tag;
         data_arr[idx] <= mem_rsp_data;
      end
   end

endmodule

`default_nettype wire

/* rtl/ncpu_ifu.sv */
// Fetch stage. holds the PC, issues one fetch at a time and
// pre-decodes the returned word to pick the next PC.
`timescale 1ns/100ps
`default_nettype none

module ncpu_ifu (
   input  wire                           clk,
   input  wire                           rst_n,
   output logic                          fetch_cmd_valid,
   output ncpu_bus_pkg::fetch_cmd_t      fetch_cmd,
   input  wire                           fetch_cmd_ready,
   input  wire                           fetch_rsp_valid,
   input  wire ncpu_bus_pkg::fetch_rsp_t fetch_rsp,
   output logic                          fetch_rsp_ready,
   output logic                          insn_valid,
   output ncpu_bus_pkg::fetch_rsp_t      insn,
   input  wire                           insn_ready
);

   localparam int unsigned aw = ncpu_cfg_pkg::ncpu_aw;

   // issue a command, or wait for the word to leave
   localparam logic is_issue = 1'b0;
   localparam logic is_wait  = 1'b1;

   localparam logic [aw-1:0] insn_bytes = 'd4;

   logic                       state_q;
   logic [aw-1:0]              pc_q;
   logic [aw-1:0]              pc_nxt;
   logic                       out_valid_q;
   ncpu_bus_pkg::fetch_rsp_t   out_q;
   ncpu_cfg_pkg::ncpu_insn_u   dec;
   logic [aw-1:0]              jmp_offs;
   logic                       hds_cmd;
   logic                       hds_rsp;
   logic                       hds_out;

   assign hds_cmd = fetch_cmd_valid & fetch_cmd_ready;
   assign hds_rsp = fetch_rsp_valid & fetch_rsp_ready;
   assign hds_out = insn_valid & insn_ready;

   // command goes out whenever we are in the issue state
   assign fetch_cmd_valid = (state_q == is_issue);
   assign fetch_cmd       = '{addr: pc_q};

   // output slot empty, so a response can land
   assign fetch_rsp_ready = ~out_valid_q;

   assign insn_valid = out_valid_q;
   assign insn       = out_q;

   // pre-decode of the word sitting in the output slot
   assign dec = out_q.insn;

   // word offset to bytes, sign extended
   assign jmp_offs = {{(aw-28){dec.jmp.offs[25]}}, dec.jmp.offs, 2'b00};

   always_comb begin
      // opcode of the generic view decides if the jump view is valid
      if (dec.gen.opc == ncpu_cfg_pkg::opc_jmp) begin
         pc_nxt = out_q.id + jmp_offs;
      end else begin
         pc_nxt = out_q.id + insn_bytes;
      end
   end

   // issue/wait flag and PC
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state_q <= is_issue;
         pc_q    <= ncpu_cfg_pkg::ncpu_erst_vector;
      end else begin
         if (hds_cmd) begin
            state_q <= is_wait;
         end else if (hds_out) begin
            // next command one cycle after the word leaves
            state_q <= is_issue;
            pc_q    <= pc_nxt;
         end
      end
   end

   // output slot valid
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         out_valid_q <= 1'b0;
      end else if (hds_rsp) begin
         out_valid_q <= 1'b1;
      end else if (hds_out) begin
         out_valid_q <= 1'b0;
      end
   end

   // payload held until the outside takes it
   always_ff @(posedge clk) begin
      if (hds_rsp) begin
         out_q <= fetch_rsp;
      end
   end

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# build the fetch front end testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --assert -j 0 --top-module tb_fetch_top -f verilog.f

out=$(./obj_dir/Vtb_fetch_top)
echo "$out"

if echo "$out" | grep -q -x -F '** PASS **'; then
   exit 0
else
   exit 1
fi

/* verification/tb_fetch_top.sv */
// Testbench for the fetch front end with a memory model, a reference
// PC/TLB/cache model and concurrent assertions on every instruction transfer.
`timescale 1ns/100ps
`default_nettype none

module tb_fetch_top;

   // fetches per test
   localparam int n_seq   = 7;
   localparam int n_jmp   = 3;
   localparam int n_tlb   = 4;
   localparam int n_loop  = 18;
   localparam int n_stall = 40;
   localparam int n_fetch_total = 1 + n_seq + n_jmp + n_tlb + n_loop + n_stall;
   // refill plus the longest ready stretch in cycles
   localparam int worst_lat = 24;
   localparam int timeout_cycles = n_fetch_total * worst_lat + 100;

   logic                           clk;
   logic                           rst_n;
   logic                           tlb_we;
   ncpu_bus_pkg::tlb_wr_t          tlb_wr;
   logic                           insn_valid;
   ncpu_bus_pkg::fetch_rsp_t       insn;
   logic                           insn_ready;
   logic                           mem_req_valid;
   ncpu_bus_pkg::mem_req_t         mem_req;
   logic                           mem_req_ready;
   logic                           mem_rsp_valid;
   logic [31:0]                    mem_rsp_data;

   // reference model state
   logic [31:0] exp_pc;
   logic [31:0] exp_paddr;
   logic [31:0] exp_word;
   logic [31:0] pc_next;
   logic        model_hit;
   logic        first_q;
   int          req_cnt;
   int          xfer_cnt;
   logic [3:0]  m_tlb_v;
   logic [19:0] m_tlb_vpn [4];
   logic [19:0] m_tlb_ppn [4];
   logic [15:0] m_line_v;
   logic [25:0] m_line_tag [16];

   int err_cnt  = 0;
   int pass_cnt = 0;
   int fail_cnt = 0;

   ncpu_fetch_top DUT (
      .clk           (clk),
      .rst_n         (rst_n),
      .tlb_we        (tlb_we),
      .tlb_wr        (tlb_wr),
      .insn_valid    (insn_valid),
      .insn          (insn),
      .insn_ready    (insn_ready),
      .mem_req_valid (mem_req_valid),
      .mem_req       (mem_req),
      .mem_req_ready (mem_req_ready),
      .mem_rsp_valid (mem_rsp_valid),
      .mem_rsp_data  (mem_rsp_data)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   function automatic logic [31:0] jmp_word(input int k);
      return {ncpu_cfg_pkg::opc_jmp, 26'(k)};
   endfunction

   // memory contents by physical byte address
   function automatic logic [31:0] mem_word(input logic [31:0] a);
      logic [31:0] w;
      // generic opcode 0 with imm from the word address
      w = {16'h0000, a[17:2]};
      case (a)
         32'h0000_0120: w = jmp_word(32);
         32'h0000_01a0: w = jmp_word(-16);
         // loops back over the sequential block
         32'h0000_0178: w = jmp_word(-29);
         default: ;
      endcase
      return w;
   endfunction

   // a hit keeps the page offset and a miss passes the address through
   function automatic logic [31:0] translate(input logic [31:0] va);
      logic [31:0] pa;
      pa = va;
      for (int i = 0; i < 4; i++) begin
         if (m_tlb_v[i] && (m_tlb_vpn[i] == va[31:12])) begin
            pa = {m_tlb_ppn[i], va[11:0]};
         end
      end
      return pa;
   endfunction

   function automatic logic [31:0] next_pc(input logic [31:0] pc, input logic [31:0] w);
      if (w[31:26] == ncpu_cfg_pkg::opc_jmp) begin
         return pc + {{4{w[25]}}, w[25:0], 2'b00};
      end
      return pc + 32'd4;
   endfunction

   assign exp_word  = mem_word(exp_paddr);
   assign pc_next   = next_pc(exp_pc, exp_word);
   // index in bits 5:2 and tag above
   assign model_hit = m_line_v[exp_paddr[5:2]] &&
                      (m_line_tag[exp_paddr[5:2]] == exp_paddr[31:6]);

   // model advances on each instruction transfer
   always @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         exp_pc    <= ncpu_cfg_pkg::ncpu_erst_vector;
         exp_paddr <= ncpu_cfg_pkg::ncpu_erst_vector;
         req_cnt   <= 0;
         xfer_cnt  <= 0;
         first_q   <= 1'b1;
         m_tlb_v   <= '0;
         m_line_v  <= '0;
      end else begin
         if (tlb_we) begin
            m_tlb_v[tlb_wr.idx]   <= tlb_wr.valid;
            m_tlb_vpn[tlb_wr.idx] <= tlb_wr.vpn;
            m_tlb_ppn[tlb_wr.idx] <= tlb_wr.ppn;
         end
         if (mem_req_valid && mem_req_ready) begin
            req_cnt <= req_cnt + 1;
         end
         if (insn_valid && insn_ready) begin
            // tlb only changes while the slot is stalled
            exp_pc    <= pc_next;
            exp_paddr <= translate(pc_next);
            req_cnt   <= 0;
            xfer_cnt  <= xfer_cnt + 1;
            first_q   <= 1'b0;
            m_line_v[exp_paddr[5:2]]   <= 1'b1;
            m_line_tag[exp_paddr[5:2]] <= exp_paddr[31:6];
         end
      end
   end

   // memory side with ready after 0-1 cycles and data after 1-4
   initial begin : mem_model
      int unsigned d;
      logic [31:0] a;
      mem_req_ready = 1'b0;
      mem_rsp_valid = 1'b0;
      mem_rsp_data  = '0;
      forever begin
         @(posedge clk);
         #1;
         mem_rsp_valid = 1'b0;
         if (mem_req_valid) begin
            if ($urandom_range(1, 0) == 1) begin
               @(posedge clk);
               #1;
            end
            mem_req_ready = 1'b1;
            a = mem_req.addr;
            @(posedge clk);
            #1;
            mem_req_ready = 1'b0;
            d = $urandom_range(4, 1);
            repeat (d - 1) begin
               @(posedge clk);
               #1;
            end
            mem_rsp_valid = 1'b1;
            mem_rsp_data  = mem_word(a);
         end
      end
   end

   a_reset_idle: assert property (@(posedge clk)
      $rose(rst_n) |-> (!insn_valid && !mem_req_valid))
      else begin
         $display("insn_valid or mem_req_valid already high right after reset");
         err_cnt++;
      end

   a_first_id: assert property (@(posedge clk) disable iff (!rst_n)
      (insn_valid && insn_ready && first_q) |->
         (insn.id == ncpu_cfg_pkg::ncpu_erst_vector))
      else begin
         $display("** Error: first insn.id = %h, expected %h", $sampled(insn.id),
                  ncpu_cfg_pkg::ncpu_erst_vector);
         err_cnt++;
      end

   a_insn_id: assert property (@(posedge clk) disable iff (!rst_n)
      (insn_valid && insn_ready) |-> (insn.id == exp_pc))
      else begin
         $display("** Error: insn.id = %h, expected %h", $sampled(insn.id), $sampled(exp_pc));
         err_cnt++;
      end

   a_insn_word: assert property (@(posedge clk) disable iff (!rst_n)
      (insn_valid && insn_ready) |-> (insn.insn == exp_word))
      else begin
         $display("** Error: insn.insn = %h, expected %h at id %h", $sampled(insn.insn),
                  $sampled(exp_word), $sampled(exp_pc));
         err_cnt++;
      end

   // one refill per miss and none on a hit
   a_refill_cnt: assert property (@(posedge clk) disable iff (!rst_n)
      (insn_valid && insn_ready) |-> (req_cnt == (model_hit ? 0 : 1)))
      else begin
         $display("** Error: mem_req count = %h, expected %h at paddr %h", $sampled(req_cnt),
                  $sampled(model_hit) ? 0 : 1, $sampled(exp_paddr));
         err_cnt++;
      end

   a_refill_addr: assert property (@(posedge clk) disable iff (!rst_n)
      (mem_req_valid && mem_req_ready) |-> (mem_req.addr == exp_paddr))
      else begin
         $display("** Error: mem_req.addr = %h, expected %h", $sampled(mem_req.addr),
                  $sampled(exp_paddr));
         err_cnt++;
      end

   a_stall_stable: assert property (@(posedge clk) disable iff (!rst_n)
      (insn_valid && !insn_ready) |=> (insn_valid && $stable(insn)))
      else begin
         $display("instruction output dropped or changed while stalled near id %h",
                  $sampled(exp_pc));
         err_cnt++;
      end

   // wait for n transfers, optionally with random ready-low stretches
   task automatic run_fetches(input int n, input bit stall);
      int target;
      int low_left;
      target   = xfer_cnt + n;
      low_left = 0;
      insn_ready = 1'b1;
      while (xfer_cnt < target) begin
         @(posedge clk);
         #1;
         if (!stall) begin
            insn_ready = 1'b1;
         end else if (low_left > 0) begin
            insn_ready = 1'b0;
            low_left--;
         end else if (insn_ready && ($urandom_range(2, 0) == 0)) begin
            // stretch of 1 to 6 cycles
            low_left = $urandom_range(5, 0);
            insn_ready = 1'b0;
         end else begin
            insn_ready = 1'b1;
         end
      end
   endtask

   // hold the output slot so no command is in flight, then write
   task automatic write_tlb(input logic [1:0] idx, input logic [19:0] vpn,
                            input logic [19:0] ppn, input logic v);
      insn_ready = 1'b0;
      while (!insn_valid) begin
         @(posedge clk);
         #1;
      end
      tlb_wr = '{idx: idx, vpn: vpn, ppn: ppn, valid: v};
      tlb_we = 1'b1;
      @(posedge clk);
      #1;
      tlb_we = 1'b0;
   endtask

   task automatic end_test(input string name, input int errs_before);
      if (err_cnt == errs_before) begin
         $display("test %s: ok, %0d fetches so far", name, xfer_cnt);
         pass_cnt++;
      end else begin
         $display("test %s: %0d check(s) failed", name, err_cnt - errs_before);
         fail_cnt++;
      end
   endtask

   initial begin : stimulus
      int errs;
      void'($urandom(28926));
      rst_n      = 1'b0;
      tlb_we     = 1'b0;
      tlb_wr     = '0;
      insn_ready = 1'b0;
      repeat (2) @(posedge clk);
      #1;
      rst_n = 1'b1;

      errs = err_cnt;
      run_fetches(1, 1'b0);
      end_test("reset", errs);

      errs = err_cnt;
      run_fetches(n_seq, 1'b0);
      end_test("sequential", errs);

      // 0x120 forward then 0x1a0 backward
      errs = err_cnt;
      run_fetches(n_jmp, 1'b0);
      end_test("jump", errs);

      // page 0 onto physical page 5, then retired again
      errs = err_cnt;
      write_tlb(2'd1, 20'h00000, 20'h00005, 1'b1);
      run_fetches(n_tlb, 1'b0);
      write_tlb(2'd1, 20'h00000, 20'h00005, 1'b0);
      end_test("tlb", errs);

      // jump back over cached lines, then index conflicts
      errs = err_cnt;
      run_fetches(n_loop, 1'b0);
      end_test("cache", errs);

      errs = err_cnt;
      run_fetches(n_stall, 1'b1);
      end_test("backpressure", errs);

      $display("tests passed: %0d, failed: %0d", pass_cnt, fail_cnt);
      if (fail_cnt == 0 && err_cnt == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

   initial begin : watchdog
      repeat (timeout_cycles) @(posedge clk);
      $display("watchdog expired, %0d of %0d fetches done", xfer_cnt, n_fetch_total);
      $display("** FAIL **");
      $finish;
   end

endmodule

`default_nettype wire

/* verilog.f */
rtl/ncpu_cfg_pkg.sv
rtl/ncpu_bus_pkg.sv
rtl/ncpu_ifu.sv
rtl/ncpu_i_mmu.sv
rtl/ncpu_icache.sv
rtl/ncpu_fetch_top.sv
verification/tb_fetch_top.sv
